// File: compile.f
source/rv_ctrl_pkg.sv
source/pipe_if.sv
source/decode_ctrl.sv
source/execute_ctrl.sv
source/result_ctrl.sv
source/rv_pipe_ctrl.sv
verification/rv_pipe_ctrl_asserts.sv
verification/tb_rv_pipe_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pipeline control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rv_pipe_ctrl \
  -f compile.f -Mdir obj_dir -o sim_rv_pipe_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rv_pipe_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
exit 1

// File: source/decode_ctrl.sv
/*
 D-stage control
 Next-PC select with jal detection, register-file bypass selects
 for the two-cycle hazard, and the D-to-X register with flush
*/
`timescale 1ns/1ps

module decode_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_ctrl_pkg::XLEN-1:0] instr,
  pipe_if.decode                       pipe,
  output logic [2:0]                   pc_sel,
  output logic                         nop_sel,
  output logic                         d_rs1_byp,
  output logic                         d_rs2_byp
);

  rv_ctrl_pkg::rv_instr_t d;
  logic                   d_is_jal;

  assign d        = instr;
  assign d_is_jal = (d.r.opcode[6:2] == rv_ctrl_pkg::OPC_JAL);
  assign nop_sel  = pipe.redirect;               // Kill the wrong-path D instruction

  always_comb begin
    if (rst) begin
      pc_sel = rv_ctrl_pkg::PC_RESET;
    end else if (pipe.redirect) begin
      pc_sel = rv_ctrl_pkg::PC_ALU;              // Target computed in X
    end else if (d_is_jal) begin
      pc_sel = rv_ctrl_pkg::PC_JAL;
    end else begin
      pc_sel = rv_ctrl_pkg::PC_PLUS4;
    end
  end

  // WF result is written this cycle, so D reads it through the bypass
  assign d_rs1_byp = pipe.wf_rd_wr && (pipe.wf_instr.r.rd == d.r.rs1);
  assign d_rs2_byp = pipe.wf_rd_wr && (pipe.wf_instr.r.rd == d.r.rs2);

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe.x_instr <= rv_ctrl_pkg::NOP_INSTR;
    end else if (pipe.redirect) begin
      pipe.x_instr <= rv_ctrl_pkg::NOP_INSTR;    // Flush
    end else begin
      pipe.x_instr <= d;
    end
  end

endmodule

// File: source/execute_ctrl.sv
/*
 X-stage control
 ALU and operand decode, branch outcome and redirect,
 ALU/MEM forwarding selects and the X-to-WF register
*/
`timescale 1ns/1ps

module execute_ctrl (
  input  logic        clk,
  input  logic        rst,
  pipe_if.execute     pipe,
  input  logic        br_eq,
  input  logic        br_lt,
  output logic [3:0]  alu_sel,
  output logic [1:0]  a_sel,
  output logic        b_sel,
  output logic        br_un,
  output logic        br_taken,
  output logic [1:0]  fwd_a_sel,
  output logic [1:0]  fwd_b_sel,
  output logic [1:0]  rs2_sel
);

  rv_ctrl_pkg::rv_instr_t x;
  logic [4:0]             opc;
  logic                   rs1_hit;
  logic                   rs2_hit;
  logic [1:0]             fwd_code;

  assign x   = pipe.x_instr;
  assign opc = x.r.opcode[6:2];

  always_comb begin
    alu_sel = rv_ctrl_pkg::ALU_ADD;
    case (opc)
      rv_ctrl_pkg::OPC_RTYPE: begin
        case (x.r.funct3)
          rv_ctrl_pkg::FNC_ADD_SUB: alu_sel = x.r.funct7[rv_ctrl_pkg::FNC2_BIT - 25] ?
                                              rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
          rv_ctrl_pkg::FNC_SRL_SRA: alu_sel = x.r.funct7[rv_ctrl_pkg::FNC2_BIT - 25] ?
                                              rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
          rv_ctrl_pkg::FNC_SLL:     alu_sel = rv_ctrl_pkg::ALU_SLL;
          rv_ctrl_pkg::FNC_SLT:     alu_sel = rv_ctrl_pkg::ALU_SLT;
          rv_ctrl_pkg::FNC_SLTU:    alu_sel = rv_ctrl_pkg::ALU_SLTU;
          rv_ctrl_pkg::FNC_XOR:     alu_sel = rv_ctrl_pkg::ALU_XOR;
          rv_ctrl_pkg::FNC_OR:      alu_sel = rv_ctrl_pkg::ALU_OR;
          default:                  alu_sel = rv_ctrl_pkg::ALU_AND;
        endcase
      end
      rv_ctrl_pkg::OPC_ITYPE: begin
        case (x.i.funct3)
          rv_ctrl_pkg::FNC_ADD_SUB: alu_sel = rv_ctrl_pkg::ALU_ADD;   // No subi
          rv_ctrl_pkg::FNC_SRL_SRA: alu_sel = x.i.imm12[rv_ctrl_pkg::FNC2_BIT - 20] ?
                                              rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
          rv_ctrl_pkg::FNC_SLL:     alu_sel = rv_ctrl_pkg::ALU_SLL;
          rv_ctrl_pkg::FNC_SLT:     alu_sel = rv_ctrl_pkg::ALU_SLT;
          rv_ctrl_pkg::FNC_SLTU:    alu_sel = rv_ctrl_pkg::ALU_SLTU;
          rv_ctrl_pkg::FNC_XOR:     alu_sel = rv_ctrl_pkg::ALU_XOR;
          rv_ctrl_pkg::FNC_OR:      alu_sel = rv_ctrl_pkg::ALU_OR;
          default:                  alu_sel = rv_ctrl_pkg::ALU_AND;
        endcase
      end
      rv_ctrl_pkg::OPC_LUI: alu_sel = rv_ctrl_pkg::ALU_LUI;
      default: alu_sel = rv_ctrl_pkg::ALU_ADD;  // Address and target adds
    endcase
  end

  assign b_sel = (opc != rv_ctrl_pkg::OPC_RTYPE);         // Immediate operand
  assign br_un = (opc == rv_ctrl_pkg::OPC_BRANCH) &&
                 ((x.r.funct3 == rv_ctrl_pkg::FNC_BLTU) ||
                  (x.r.funct3 == rv_ctrl_pkg::FNC_BGEU));

  always_comb begin
    br_taken = 1'b0;
    if (opc == rv_ctrl_pkg::OPC_BRANCH) begin
      case (x.r.funct3)
        rv_ctrl_pkg::FNC_BEQ:  br_taken = br_eq;
        rv_ctrl_pkg::FNC_BNE:  br_taken = !br_eq;
        rv_ctrl_pkg::FNC_BLT,
        rv_ctrl_pkg::FNC_BLTU: br_taken = br_lt;
        rv_ctrl_pkg::FNC_BGE,
        rv_ctrl_pkg::FNC_BGEU: br_taken = !br_lt;
        default:               br_taken = 1'b0;
      endcase
    end
  end

  assign pipe.redirect = br_taken || (opc == rv_ctrl_pkg::OPC_JALR);

  // Forwarding from the WF result
  assign rs1_hit  = pipe.wf_rd_wr && (pipe.wf_instr.r.rd == x.r.rs1);
  assign rs2_hit  = pipe.wf_rd_wr && (pipe.wf_instr.r.rd == x.r.rs2);
  assign fwd_code = pipe.wf_is_load ? rv_ctrl_pkg::FWD_MEM : rv_ctrl_pkg::FWD_ALU;

  assign fwd_a_sel = rs1_hit ? fwd_code : rv_ctrl_pkg::FWD_REG;
  assign fwd_b_sel = rs2_hit ? fwd_code : rv_ctrl_pkg::FWD_REG;
  assign rs2_sel   = (opc == rv_ctrl_pkg::OPC_STORE && rs2_hit) ?
                     fwd_code : rv_ctrl_pkg::FWD_REG;      // Store data

  always_comb begin
    if (opc == rv_ctrl_pkg::OPC_BRANCH || opc == rv_ctrl_pkg::OPC_JAL ||
        opc == rv_ctrl_pkg::OPC_AUIPC) begin
      a_sel = rv_ctrl_pkg::FWD_ALU;                        // Code 1 picks the PC
    end else if (opc == rv_ctrl_pkg::OPC_STORE && rs1_hit && pipe.wf_is_load) begin
      a_sel = rv_ctrl_pkg::FWD_MEM;                        // Loaded store base
    end else begin
      a_sel = rv_ctrl_pkg::FWD_REG;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe.wf_instr <= rv_ctrl_pkg::NOP_INSTR;
    end else begin
      pipe.wf_instr <= x;
    end
  end

endmodule

// File: source/pipe_if.sv
/*
 Stage-to-stage links of the pipeline control unit
 X and WF instruction words, X redirect, WF write status
*/
`timescale 1ns/1ps

interface pipe_if;

  rv_ctrl_pkg::rv_instr_t x_instr;   // Instruction in X
  rv_ctrl_pkg::rv_instr_t wf_instr;  // Instruction in WF
  logic                   redirect;  // Taken branch or jalr in X
  logic                   wf_rd_wr;  // WF writes a nonzero rd
  logic                   wf_is_load;

  modport decode (
    output x_instr,
    input  redirect, wf_instr, wf_rd_wr
  );

  modport execute (
    input  x_instr, wf_rd_wr, wf_is_load,
    output redirect, wf_instr
  );

  modport result (
    input  wf_instr,
    output wf_rd_wr, wf_is_load
  );

endinterface

// File: source/result_ctrl.sv
/*
 WF-stage control
 Register-file write enable, write-back and load-extension selects,
 and the WF write status used by the hazard checks
*/
`timescale 1ns/1ps

module result_ctrl (
  pipe_if.result     pipe,
  output logic       rf_we,
  output logic [1:0] wb_sel,
  output logic [2:0] ldx_sel
);

  rv_ctrl_pkg::rv_instr_t wf;
  logic [4:0]             opc;
  logic                   writes_rd;

  assign wf  = pipe.wf_instr;
  assign opc = wf.i.opcode[6:2];

  always_comb begin
    case (opc)
      rv_ctrl_pkg::OPC_RTYPE, rv_ctrl_pkg::OPC_ITYPE, rv_ctrl_pkg::OPC_LOAD,
      rv_ctrl_pkg::OPC_JAL, rv_ctrl_pkg::OPC_JALR,
      rv_ctrl_pkg::OPC_AUIPC, rv_ctrl_pkg::OPC_LUI: writes_rd = 1'b1;
      default: writes_rd = 1'b0;                   // Store, branch, unknown
    endcase
  end

  assign rf_we           = writes_rd && (wf.i.rd != '0);  // x0 never written
  assign pipe.wf_rd_wr   = rf_we;
  assign pipe.wf_is_load = (opc == rv_ctrl_pkg::OPC_LOAD);

  assign wb_sel = (opc == rv_ctrl_pkg::OPC_LOAD) ? rv_ctrl_pkg::WB_MEM :
                  (opc == rv_ctrl_pkg::OPC_JAL || opc == rv_ctrl_pkg::OPC_JALR) ?
                  rv_ctrl_pkg::WB_PC4 : rv_ctrl_pkg::WB_ALU;

  always_comb begin
    ldx_sel = rv_ctrl_pkg::LDX_LW;
    if (opc == rv_ctrl_pkg::OPC_LOAD) begin
      case (wf.i.funct3)
        rv_ctrl_pkg::FNC_LB:  ldx_sel = rv_ctrl_pkg::LDX_LB;
        rv_ctrl_pkg::FNC_LBU: ldx_sel = rv_ctrl_pkg::LDX_LBU;
        rv_ctrl_pkg::FNC_LH:  ldx_sel = rv_ctrl_pkg::LDX_LH;
        rv_ctrl_pkg::FNC_LHU: ldx_sel = rv_ctrl_pkg::LDX_LHU;
        rv_ctrl_pkg::FNC_LW:  ldx_sel = rv_ctrl_pkg::LDX_LW;
        default:              ldx_sel = rv_ctrl_pkg::LDX_LW;
      endcase
    end
  end

endmodule

// File: source/rv_ctrl_pkg.sv
/*
 Shared definitions for the RV32I pipeline control unit
 Widths, opcode and funct3 codes, select codes for the datapath muxes,
 the NOP word and the instruction word union
*/
package rv_ctrl_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Opcode bits 6..2
  localparam logic [4:0] OPC_RTYPE  = 5'b01100;
  localparam logic [4:0] OPC_ITYPE  = 5'b00100;
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_LUI    = 5'b01101;

  // Arithmetic funct3
  localparam logic [2:0] FNC_ADD_SUB = 3'b000;
  localparam logic [2:0] FNC_SLL     = 3'b001;
  localparam logic [2:0] FNC_SLT     = 3'b010;
  localparam logic [2:0] FNC_SLTU    = 3'b011;
  localparam logic [2:0] FNC_XOR     = 3'b100;
  localparam logic [2:0] FNC_SRL_SRA = 3'b101;
  localparam logic [2:0] FNC_OR      = 3'b110;
  localparam logic [2:0] FNC_AND     = 3'b111;

  // Load funct3
  localparam logic [2:0] FNC_LB  = 3'b000;
  localparam logic [2:0] FNC_LH  = 3'b001;
  localparam logic [2:0] FNC_LW  = 3'b010;
  localparam logic [2:0] FNC_LBU = 3'b100;
  localparam logic [2:0] FNC_LHU = 3'b101;

  // Branch funct3
  localparam logic [2:0] FNC_BEQ  = 3'b000;
  localparam logic [2:0] FNC_BNE  = 3'b001;
  localparam logic [2:0] FNC_BLT  = 3'b100;
  localparam logic [2:0] FNC_BGE  = 3'b101;
  localparam logic [2:0] FNC_BLTU = 3'b110;
  localparam logic [2:0] FNC_BGEU = 3'b111;

  localparam int FNC2_BIT = 30;            // Set for SUB and SRA

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_XOR  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_SLT  = 4'd8;
  localparam logic [3:0] ALU_SLTU = 4'd9;
  localparam logic [3:0] ALU_LUI  = 4'd10;

  localparam logic [1:0] WB_MEM = 2'd0;
  localparam logic [1:0] WB_ALU = 2'd1;
  localparam logic [1:0] WB_PC4 = 2'd2;

  localparam logic [2:0] LDX_LW  = 3'd0;
  localparam logic [2:0] LDX_LHU = 3'd1;
  localparam logic [2:0] LDX_LH  = 3'd2;
  localparam logic [2:0] LDX_LBU = 3'd3;
  localparam logic [2:0] LDX_LB  = 3'd4;

  localparam logic [2:0] PC_RESET = 3'd0;
  localparam logic [2:0] PC_JAL   = 3'd1;
  localparam logic [2:0] PC_PLUS4 = 3'd2;
  localparam logic [2:0] PC_ALU   = 3'd3;

  localparam logic [1:0] FWD_REG = 2'd0;
  localparam logic [1:0] FWD_ALU = 2'd1;   // Also PC on a_sel
  localparam logic [1:0] FWD_MEM = 2'd2;

  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

  // R view and I view of one instruction word
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r;
    struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i;
  } rv_instr_t;

endpackage

// File: source/rv_pipe_ctrl.sv
/*
 Top level of the three-stage RV32I pipeline control unit
 Connects the decode, execute and result stage controls
*/
`timescale 1ns/1ps

module rv_pipe_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_ctrl_pkg::XLEN-1:0] instr,
  input  logic                         br_eq,
  input  logic                         br_lt,
  output logic [2:0]                   pc_sel,
  output logic                         nop_sel,
  output logic                         d_rs1_byp,
  output logic                         d_rs2_byp,
  output logic [3:0]                   alu_sel,
  output logic [1:0]                   a_sel,
  output logic                         b_sel,
  output logic                         br_un,
  output logic                         br_taken,
  output logic [1:0]                   fwd_a_sel,
  output logic [1:0]                   fwd_b_sel,
  output logic [1:0]                   rs2_sel,
  output logic                         rf_we,
  output logic [1:0]                   wb_sel,
  output logic [2:0]                   ldx_sel
);

  pipe_if pipe ();

  decode_ctrl i_decode (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .pipe      (pipe.decode),
    .pc_sel    (pc_sel),
    .nop_sel   (nop_sel),
    .d_rs1_byp (d_rs1_byp),
    .d_rs2_byp (d_rs2_byp)
  );

  execute_ctrl i_execute (
    .clk       (clk),
    .rst       (rst),
    .pipe      (pipe.execute),
    .br_eq     (br_eq),
    .br_lt     (br_lt),
    .alu_sel   (alu_sel),
    .a_sel     (a_sel),
    .b_sel     (b_sel),
    .br_un     (br_un),
    .br_taken  (br_taken),
    .fwd_a_sel (fwd_a_sel),
    .fwd_b_sel (fwd_b_sel),
    .rs2_sel   (rs2_sel)
  );

  result_ctrl i_result (
    .pipe    (pipe.result),
    .rf_we   (rf_we),
    .wb_sel  (wb_sel),
    .ldx_sel (ldx_sel)
  );

endmodule

// File: verification/rv_pipe_ctrl_asserts.sv
/*
 Concurrent checks bound to the control unit top level
 Reset PC select, flush only with a redirect, no write after reset
*/
`timescale 1ns/1ps

module rv_pipe_ctrl_asserts (
  input logic       clk,
  input logic       rst,
  input logic [2:0] pc_sel,
  input logic       nop_sel,
  input logic       rf_we
);

  reset_pc_check: assert property (@(posedge clk)
    rst |-> (pc_sel == rv_ctrl_pkg::PC_RESET))
    else $error("pc_sel is not the reset select while rst is high");

  // A flushed D instruction always goes with the X target
  flush_pc_check: assert property (@(posedge clk) disable iff (rst)
    nop_sel |-> (pc_sel == rv_ctrl_pkg::PC_ALU))
    else $error("nop_sel high without the ALU PC select");

  release_we_check: assert property (@(posedge clk)
    $fell(rst) |-> !rf_we)
    else $error("rf_we high in the first cycle after reset release");

endmodule

bind rv_pipe_ctrl rv_pipe_ctrl_asserts i_asserts (
  .clk     (clk),
  .rst     (rst),
  .pc_sel  (pc_sel),
  .nop_sel (nop_sel),
  .rf_we   (rf_we)
);

// File: verification/tb_rv_pipe_ctrl.sv
/*
 Testbench for the RV32I pipeline control unit
 Clock and reset, table of instructions with expected selects,
 table loop with checks, per-test lines and the final report
*/
`timescale 1ns/1ps

module tb_rv_pipe_ctrl;

  localparam int          SETTLE      = 10;  // ns after the driving edge
  localparam int          RST_TIMEOUT = 10;  // Cycles
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

  // RV32I major opcodes
  localparam int OP_IMM   = 'h13;
  localparam int OP_LOAD  = 'h03;
  localparam int OP_JALR  = 'h67;
  localparam int OP_JAL   = 'h6f;
  localparam int OP_LUI   = 'h37;
  localparam int OP_AUIPC = 'h17;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] instr;
  logic        br_eq;
  logic        br_lt;
  logic [2:0]  pc_sel;
  logic        nop_sel;
  logic        d_rs1_byp;
  logic        d_rs2_byp;
  logic [3:0]  alu_sel;
  logic [1:0]  a_sel;
  logic        b_sel;
  logic        br_un;
  logic        br_taken;
  logic [1:0]  fwd_a_sel;
  logic [1:0]  fwd_b_sel;
  logic [1:0]  rs2_sel;
  logic        rf_we;
  logic [1:0]  wb_sel;
  logic [2:0]  ldx_sel;

  // One row per cycle, two checked outputs each
  string       row_name [$];
  logic [31:0] row_instr [$];
  int          row_eq [$];
  int          row_lt [$];
  string       row_sig_a [$];
  int          row_exp_a [$];
  string       row_sig_b [$];
  int          row_exp_b [$];

  int error_count;
  int pass_count;
  int fail_count;

  rv_pipe_ctrl i_dut (.*);

  always #20 clk = ~clk;

  initial begin : drive_reset
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

  function automatic logic [31:0] r_word(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_word(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_word(int rs2, int rs1, int f3, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_word(int rs2, int rs1, int f3);
    return {7'd0, rs2[4:0], rs1[4:0], f3[2:0], 5'd0, 7'h63};  // Offset 0
  endfunction

  function automatic logic [31:0] u_word(int imm, int rd, int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  task automatic add_row(string name, logic [31:0] word, int eq, int lt,
                         string sig_a, int exp_a, string sig_b, int exp_b);
    row_name.push_back(name);
    row_instr.push_back(word);
    row_eq.push_back(eq);
    row_lt.push_back(lt);
    row_sig_a.push_back(sig_a);
    row_exp_a.push_back(exp_a);
    row_sig_b.push_back(sig_b);
    row_exp_b.push_back(exp_b);
  endtask

  function automatic int read_output(string sig);
    int value;
    value = -1;                                     // Unknown output name
    if (sig == "pc_sel") value = int'(pc_sel);
    else if (sig == "nop_sel") value = int'(nop_sel);
    else if (sig == "d_rs1_byp") value = int'(d_rs1_byp);
    else if (sig == "d_rs2_byp") value = int'(d_rs2_byp);
    else if (sig == "alu_sel") value = int'(alu_sel);
    else if (sig == "a_sel") value = int'(a_sel);
    else if (sig == "b_sel") value = int'(b_sel);
    else if (sig == "br_un") value = int'(br_un);
    else if (sig == "br_taken") value = int'(br_taken);
    else if (sig == "fwd_a_sel") value = int'(fwd_a_sel);
    else if (sig == "fwd_b_sel") value = int'(fwd_b_sel);
    else if (sig == "rs2_sel") value = int'(rs2_sel);
    else if (sig == "rf_we") value = int'(rf_we);
    else if (sig == "wb_sel") value = int'(wb_sel);
    else if (sig == "ldx_sel") value = int'(ldx_sel);
    return value;
  endfunction

  task automatic check_value(string test, string sig, int expected);
    int actual;
    actual = read_output(sig);
    assert (actual == expected) else begin
      $display("Error: %s %s expected %0d actual %0d", test, sig, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(string test, int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("%-16s pass", test);
    end else begin
      fail_count++;
      $display("%-16s fail", test);
    end
  endtask

  // D enters on row n, X holds row n-1, WF holds row n-2
  task automatic build_table();
    add_row("add_pc4",        r_word(0, 3, 2, 0, 1),   0, 0, "pc_sel", 2, "d_rs1_byp", 0);
    add_row("add_alu",        r_word(32, 5, 1, 0, 4),  0, 0, "alu_sel", 0, "b_sel", 0);
    add_row("sub_fwd_alu",    r_word(32, 1, 4, 5, 6),  0, 0, "alu_sel", 1, "fwd_a_sel", 1);
    add_row("sra_fwd_alu",    i_word('h403, 6, 5, 7, OP_IMM), 0, 0, "alu_sel", 7, "fwd_a_sel", 1);
    add_row("srai_alu",       r_word(0, 0, 7, 2, 2),   0, 0, "alu_sel", 7, "b_sel", 1);
    add_row("slt_alu",        i_word('hff, 2, 7, 3, OP_IMM), 0, 0, "alu_sel", 8, "b_sel", 0);
    add_row("andi_fwd_alu",   u_word('h12345, 5, OP_LUI), 0, 0, "alu_sel", 2, "fwd_a_sel", 1);
    add_row("lui_alu",        i_word(0, 9, 2, 8, OP_LOAD), 0, 0, "alu_sel", 10, "b_sel", 1);
    add_row("lw_no_fwd",      r_word(0, 11, 8, 0, 10), 0, 0, "alu_sel", 0, "fwd_a_sel", 0);
    add_row("load_fwd_mem",   i_word(0, 1, 2, 12, OP_LOAD), 0, 0, "fwd_a_sel", 2, "ldx_sel", 0);
    add_row("add_wb_alu",     s_word(12, 12, 2, 8),    0, 0, "rf_we", 1, "wb_sel", 1);
    add_row("store_fwd_mem",  i_word(1, 12, 0, 0, OP_IMM), 0, 0, "rs2_sel", 2, "a_sel", 2);
    add_row("store_no_we",    r_word(0, 0, 0, 0, 13),  0, 0, "rf_we", 0, "a_sel", 0);
    add_row("x0_fwd_reg",     i_word(1, 3, 6, 16, OP_IMM), 0, 0, "fwd_a_sel", 0, "fwd_b_sel", 0);
    add_row("d_rs1_bypass",   r_word(0, 1, 13, 0, 16), 0, 0, "d_rs1_byp", 1, "d_rs2_byp", 0);
    add_row("d_rs2_bypass",   r_word(32, 16, 2, 0, 15), 0, 0, "d_rs2_byp", 1, "d_rs1_byp", 0);
    add_row("sub_fwd_b_alu",  b_word(2, 1, 0),         0, 0, "alu_sel", 1, "fwd_b_sel", 1);
    add_row("beq_taken",      r_word(32, 2, 1, 0, 20), 1, 0, "br_taken", 1, "pc_sel", 3);
    add_row("flush_nop",      b_word(4, 3, 1),         0, 0, "alu_sel", 0, "b_sel", 1);
    add_row("bne_not_taken",  r_word(0, 2, 1, 0, 21),  1, 0, "br_taken", 0, "rf_we", 0);
    add_row("after_bne",      b_word(6, 5, 4),         0, 0, "nop_sel", 0, "pc_sel", 2);
    add_row("blt_taken",      r_word(32, 2, 1, 0, 22), 0, 1, "br_taken", 1, "nop_sel", 1);
    add_row("flush_pc4",      b_word(6, 5, 5),         0, 0, "pc_sel", 2, "alu_sel", 0);
    add_row("bge_not_taken",  r_word(0, 2, 1, 4, 23),  0, 1, "br_taken", 0, "br_un", 0);
    add_row("xor_alu",        b_word(8, 7, 6),         0, 0, "alu_sel", 4, "rf_we", 0);
    add_row("bltu_not_taken", r_word(0, 2, 1, 6, 24),  0, 0, "br_taken", 0, "br_un", 1);
    add_row("or_alu",         b_word(8, 7, 7),         0, 0, "alu_sel", 3, "rf_we", 0);
    add_row("bgeu_taken",     r_word(0, 2, 1, 1, 25),  0, 0, "br_taken", 1, "br_un", 1);
    add_row("jal_pc",         u_word('h00400, 1, OP_JAL), 0, 0, "pc_sel", 1, "nop_sel", 0);
    add_row("jal_a_pc",       i_word(0, 2, 0, 26, OP_LOAD), 0, 0, "a_sel", 1, "rf_we", 0);
    add_row("jal_wb_pc4",     i_word(0, 2, 4, 27, OP_LOAD), 0, 0, "wb_sel", 2, "rf_we", 1);
    add_row("lb_ldx",         i_word(0, 2, 1, 28, OP_LOAD), 0, 0, "ldx_sel", 4, "wb_sel", 0);
    add_row("lbu_ldx",        i_word(0, 2, 5, 29, OP_LOAD), 0, 0, "ldx_sel", 3, "wb_sel", 0);
    add_row("lh_ldx",         i_word(0, 1, 0, 30, OP_JALR), 0, 0, "ldx_sel", 2, "rf_we", 1);
    add_row("jalr_redirect",  u_word(1, 31, OP_AUIPC), 0, 0, "pc_sel", 3, "ldx_sel", 1);
    add_row("jalr_wb_pc4",    NOP_WORD,                0, 0, "wb_sel", 2, "nop_sel", 0);
    add_row("flush_no_we",    u_word(2, 31, OP_AUIPC), 0, 0, "rf_we", 0, "alu_sel", 0);
    add_row("auipc_a_pc",     NOP_WORD,                0, 0, "a_sel", 1, "b_sel", 1);
    add_row("auipc_we",       NOP_WORD,                0, 0, "rf_we", 1, "wb_sel", 1);
  endtask

  // Pipeline holds NOPs right after reset
  task automatic check_idle();
    int errors_before;
    errors_before = error_count;
    #(SETTLE - 1);
    check_value("idle", "nop_sel", 0);
    check_value("idle", "br_taken", 0);
    check_value("idle", "rf_we", 0);
    check_value("idle", "d_rs1_byp", 0);
    check_value("idle", "d_rs2_byp", 0);
    check_value("idle", "fwd_a_sel", 0);
    check_value("idle", "fwd_b_sel", 0);
    check_value("idle", "rs2_sel", 0);
    report_test("idle", errors_before);
  endtask

  task automatic apply_rows();
    int errors_before;
    for (int i = 0; i < row_name.size(); i++) begin
      @(posedge clk);
      instr <= row_instr[i];
      br_eq <= row_eq[i][0];
      br_lt <= row_lt[i][0];
      #SETTLE;
      errors_before = error_count;
      check_value(row_name[i], row_sig_a[i], row_exp_a[i]);
      check_value(row_name[i], row_sig_b[i], row_exp_b[i]);
      report_test(row_name[i], errors_before);
    end
  endtask

  initial begin : main
    int cycles;
    int errors_before;
    instr       = NOP_WORD;
    br_eq       = 1'b0;
    br_lt       = 1'b0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    build_table();
    @(posedge clk);
    #SETTLE;
    errors_before = error_count;
    check_value("reset_pc", "pc_sel", 0);
    report_test("reset_pc", errors_before);
    cycles = 0;
    while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("Timeout: reset was still high after %0d cycles", RST_TIMEOUT);
      $display("Test FAILED");
    end else begin
      check_idle();
      apply_rows();
      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
    end
    $finish;
  end

endmodule
